// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it into sim.log, then look for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_tlb -f src.f -o tb_tlb \
	&& ./obj_dir/tb_tlb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0

// File: src.f
src/tlb_pkg.sv
src/axil_pkg.sv
src/tlb_fill_if.sv
src/tlb_fill_ctrl.sv
src/tlb_way.sv
src/tlb_hit_select.sv
src/tlb_top.sv
+incdir+testbench
testbench/tb_tlb.sv

// File: src/axil_pkg.sv
// ====================
// axi4-lite codes and fill port register map
// ====================
package axil_pkg;

	localparam int AXIL_ADDR_W = 8;
	localparam int AXIL_DATA_W = 32;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// register offsets
	localparam logic [AXIL_ADDR_W-1:0] REG_VPN    = 8'h00;
	localparam logic [AXIL_ADDR_W-1:0] REG_PPN    = 8'h04;
	localparam logic [AXIL_ADDR_W-1:0] REG_ATTR   = 8'h08;
	localparam logic [AXIL_ADDR_W-1:0] REG_COMMIT = 8'h0C;
	localparam logic [AXIL_ADDR_W-1:0] REG_FLUSH  = 8'h10;
	localparam logic [AXIL_ADDR_W-1:0] REG_VICTIM = 8'h14;

	// field positions inside REG_ATTR
	localparam int ATTR_VALID_BIT  = 0;
	localparam int ATTR_GLOBAL_BIT = 1;
	localparam int ATTR_RIGHTS_LSB = 2;
	localparam int ATTR_ASID_LSB   = 8;
	// REG_COMMIT: set means round-robin victim
	localparam int COMMIT_RR_BIT   = 31;

endpackage

// File: src/tlb_fill_ctrl.sv
`timescale 1ns/1ns

module tlb_fill_ctrl (
	input  logic                          clk_g,
	input  logic                          rst_i,
	input  logic [axil_pkg::AXIL_ADDR_W-1:0] s_awaddr_i,
	input  logic                          s_awvalid_i,
	output logic                          s_awready_o,
	input  logic [axil_pkg::AXIL_DATA_W-1:0] s_wdata_i,
	input  logic                          s_wvalid_i,
	output logic                          s_wready_o,
	output logic [1:0]                    s_bresp_o,
	output logic                          s_bvalid_o,
	input  logic                          s_bready_i,
	input  logic [axil_pkg::AXIL_ADDR_W-1:0] s_araddr_i,
	input  logic                          s_arvalid_i,
	output logic                          s_arready_o,
	output logic [axil_pkg::AXIL_DATA_W-1:0] s_rdata_o,
	output logic [1:0]                    s_rresp_o,
	output logic                          s_rvalid_o,
	input  logic                          s_rready_i,
	tlb_fill_if.filler                    fill [tlb_pkg::TLB_WAYS]
);
	import tlb_pkg::*;
	import axil_pkg::*;

	logic                   wr_fire;
	logic                   rd_fire;
	logic                   wr_ok;
	logic                   is_commit;
	logic                   is_flush;
	logic [WAY_BITS-1:0]    victim_q;
	logic [WAY_BITS-1:0]    commit_way;
	way_mask_t              wr_mask;
	logic                   flush_pulse;
	logic [AXIL_DATA_W-1:0] rd_data;
	logic                   rd_ok;
	// staged entry fields
	vpn_t                   stage_vpn_q;
	ppn_t                   stage_ppn_q;
	asid_t                  stage_asid_q;
	rights_t                stage_rights_q;
	logic                   stage_valid_q;
	logic                   stage_glob_q;
	tlb_entry_t             stage_entry;

	// ====================
	// write channel
	// ====================
	// ready pulses one cycle after both valids, never while a response waits
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			s_awready_o <= 1'b0;
			s_wready_o  <= 1'b0;
		end else begin
			s_awready_o <= s_awvalid_i & s_wvalid_i & ~s_awready_o & ~s_bvalid_o;
			s_wready_o  <= s_awvalid_i & s_wvalid_i & ~s_awready_o & ~s_bvalid_o;
		end
	end

	assign wr_fire = s_awready_o & s_awvalid_i & s_wvalid_i;

	// offset decode for the accepted write
	always_comb begin
		wr_ok     = 1'b1;
		is_commit = 1'b0;
		is_flush  = 1'b0;
		case (s_awaddr_i)
			REG_VPN, REG_PPN, REG_ATTR: ;
			REG_COMMIT: is_commit = 1'b1;
			REG_FLUSH:  is_flush  = 1'b1;
			// REG_VICTIM is read-only, rest undefined
			default:    wr_ok     = 1'b0;
		endcase
	end

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			s_bvalid_o <= 1'b0;
		end else if (wr_fire) begin
			s_bvalid_o <= 1'b1;
		end else if (s_bready_i) begin
			s_bvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_g) begin
		if (wr_fire) begin
			s_bresp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// staging registers, payload only
	always_ff @(posedge clk_g) begin
		if (wr_fire) begin
			case (s_awaddr_i)
				REG_VPN: stage_vpn_q <= s_wdata_i[$bits(vpn_t)-1:0];
				REG_PPN: stage_ppn_q <= s_wdata_i[$bits(ppn_t)-1:0];
				REG_ATTR: begin
					stage_valid_q  <= s_wdata_i[ATTR_VALID_BIT];
					stage_glob_q   <= s_wdata_i[ATTR_GLOBAL_BIT];
					stage_rights_q <= s_wdata_i[ATTR_RIGHTS_LSB +: $bits(rights_t)];
					stage_asid_q   <= s_wdata_i[ATTR_ASID_LSB +: $bits(asid_t)];
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		stage_entry.valid  = stage_valid_q;
		stage_entry.glob   = stage_glob_q;
		stage_entry.asid   = stage_asid_q;
		stage_entry.vpn    = stage_vpn_q;
		stage_entry.ppn    = stage_ppn_q;
		stage_entry.rights = stage_rights_q;
	end

	// ====================
	// victim and fill pulses
	// ====================
	assign commit_way = s_wdata_i[COMMIT_RR_BIT] ? victim_q : s_wdata_i[WAY_BITS-1:0];
	assign wr_mask = (wr_fire && is_commit) ? (way_mask_t'(1) << commit_way) : '0;
	assign flush_pulse = wr_fire & is_flush;

	// round-robin pointer, wraps modulo the way count
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			victim_q <= '0;
		end else if (wr_fire && is_commit && s_wdata_i[COMMIT_RR_BIT]) begin
			victim_q <= victim_q + 1'b1;
		end
	end

	for (genvar g = 0; g < TLB_WAYS; g++) begin : g_fill
		assign fill[g].wr_en    = wr_mask[g];
		assign fill[g].wr_set   = stage_vpn_q[SET_BITS-1:0];
		assign fill[g].wr_entry = stage_entry;
		assign fill[g].flush    = flush_pulse;
	end

	// ====================
	// read channel
	// ====================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			s_arready_o <= 1'b0;
		end else begin
			s_arready_o <= s_arvalid_i & ~s_arready_o & ~s_rvalid_o;
		end
	end

	assign rd_fire = s_arready_o & s_arvalid_i;

	always_comb begin
		rd_data = '0;
		rd_ok   = 1'b1;
		case (s_araddr_i)
			REG_VPN: rd_data = AXIL_DATA_W'(stage_vpn_q);
			REG_PPN: rd_data = AXIL_DATA_W'(stage_ppn_q);
			REG_ATTR: begin
				rd_data[ATTR_VALID_BIT]  = stage_valid_q;
				rd_data[ATTR_GLOBAL_BIT] = stage_glob_q;
				rd_data[ATTR_RIGHTS_LSB +: $bits(rights_t)] = stage_rights_q;
				rd_data[ATTR_ASID_LSB +: $bits(asid_t)]     = stage_asid_q;
			end
			// command registers read back as zero
			REG_COMMIT, REG_FLUSH: ;
			REG_VICTIM: rd_data = AXIL_DATA_W'(victim_q);
			default: rd_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			s_rvalid_o <= 1'b0;
		end else if (rd_fire) begin
			s_rvalid_o <= 1'b1;
		end else if (s_rready_i) begin
			s_rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_g) begin
		if (rd_fire) begin
			s_rdata_o <= rd_data;
			s_rresp_o <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// responses hold until the master takes them
	a_bvalid_hold: assert property (@(posedge clk_g) disable iff (rst_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o);
	a_rvalid_hold: assert property (@(posedge clk_g) disable iff (rst_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o);
	// a commit fills for a single cycle, never twice in a row
	a_one_fill: assert property (@(posedge clk_g) disable iff (rst_i)
		|wr_mask |=> wr_mask == '0);

endmodule

// File: src/tlb_fill_if.sv
`timescale 1ns/1ns

// write and flush commands for one way
interface tlb_fill_if;
	import tlb_pkg::*;

	// single-cycle write strobe
	logic                wr_en;
	// set index of the entry being written
	logic [SET_BITS-1:0] wr_set;
	// full entry, valid bit included
	tlb_entry_t          wr_entry;
	// single-cycle pulse, drops every valid bit
	logic                flush;

	// fill controller side
	modport filler (
		output wr_en,
		output wr_set,
		output wr_entry,
		output flush
	);

	// storage side
	modport way (
		input wr_en,
		input wr_set,
		input wr_entry,
		input flush
	);

endinterface

// File: src/tlb_hit_select.sv
`timescale 1ns/1ns

module tlb_hit_select (
	input  logic                 clk_g,
	input  logic                 rst_i,
	input  tlb_pkg::way_result_t results_i [tlb_pkg::TLB_WAYS],
	input  logic                 req_valid_i,
	input  tlb_pkg::vaddr_t      req_vaddr_i,
	input  logic                 req_xlat_en_i,
	output logic                 result_valid_o,
	output tlb_pkg::paddr_t      paddr_o,
	output tlb_pkg::rights_t     rights_o,
	output logic                 miss_o
);
	import tlb_pkg::*;

	way_mask_t  hit_mask;
	tlb_entry_t hit_entry;
	logic       any_hit;

	// ====================
	// way merge
	// ====================
	// at most one way hits, so the last match wins without priority cost
	always_comb begin
		hit_mask  = '0;
		hit_entry = '0;
		for (int w = 0; w < TLB_WAYS; w++) begin
			hit_mask[w] = results_i[w].hit;
			if (results_i[w].hit) begin
				hit_entry = results_i[w].entry;
			end
		end
	end

	assign any_hit = |hit_mask;

	// ====================
	// output stage
	// ====================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= req_valid_i;
		end
	end

	// outputs hold between requests
	always_ff @(posedge clk_g) begin
		if (req_valid_i) begin
			if (!req_xlat_en_i) begin
				// pass-through with full rights
				paddr_o  <= req_vaddr_i;
				rights_o <= '1;
				miss_o   <= 1'b0;
			end else if (any_hit) begin
				// ppn followed by the page offset
				paddr_o  <= {hit_entry.ppn, req_vaddr_i[PAGE_BITS-1:0]};
				rights_o <= hit_entry.rights;
				miss_o   <= 1'b0;
			end else begin
				paddr_o  <= '0;
				rights_o <= '0;
				miss_o   <= 1'b1;
			end
		end
	end

	// software must never load the same page twice in a set
	a_single_hit: assert property (@(posedge clk_g) disable iff (rst_i)
		req_valid_i && req_xlat_en_i |-> $onehot0(hit_mask));

endmodule

// File: src/tlb_pkg.sv
// ====================
// translation types and buffer geometry
// ====================
package tlb_pkg;

	// geometry
	localparam int TLB_WAYS  = 4;
	localparam int TLB_SETS  = 16;
	localparam int SET_BITS  = 4;
	localparam int WAY_BITS  = 2;
	// 4 KB pages
	localparam int PAGE_BITS = 12;

	typedef logic [31:0] vaddr_t;
	typedef logic [31:0] paddr_t;
	// low SET_BITS of the vpn pick the set
	typedef logic [19:0] vpn_t;
	typedef logic [19:0] ppn_t;
	typedef logic [7:0]  asid_t;
	// read, write, execute
	typedef logic [2:0]  rights_t;

	// one stored translation, 53 bits
	typedef struct packed {
		logic    valid;
		// global entries ignore the asid
		logic    glob;
		asid_t   asid;
		vpn_t    vpn;
		ppn_t    ppn;
		rights_t rights;
	} tlb_entry_t;

	// what a way reports for one lookup
	typedef struct packed {
		logic       hit;
		tlb_entry_t entry;
	} way_result_t;

	typedef logic [TLB_WAYS-1:0] way_mask_t;

endpackage

// File: src/tlb_top.sv
`timescale 1ns/1ns

module tlb_top (
	input  logic                             clk_g,
	input  logic                             rst_i,
	// axi4-lite fill port
	input  logic [axil_pkg::AXIL_ADDR_W-1:0] s_awaddr_i,
	input  logic                             s_awvalid_i,
	output logic                             s_awready_o,
	input  logic [axil_pkg::AXIL_DATA_W-1:0] s_wdata_i,
	input  logic                             s_wvalid_i,
	output logic                             s_wready_o,
	output logic [1:0]                       s_bresp_o,
	output logic                             s_bvalid_o,
	input  logic                             s_bready_i,
	input  logic [axil_pkg::AXIL_ADDR_W-1:0] s_araddr_i,
	input  logic                             s_arvalid_i,
	output logic                             s_arready_o,
	output logic [axil_pkg::AXIL_DATA_W-1:0] s_rdata_o,
	output logic [1:0]                       s_rresp_o,
	output logic                             s_rvalid_o,
	input  logic                             s_rready_i,
	// lookup port, two-cycle latency
	input  logic                             lookup_valid_i,
	input  tlb_pkg::vaddr_t                  vaddr_i,
	input  tlb_pkg::asid_t                   asid_i,
	input  logic                             xlat_en_i,
	output logic                             result_valid_o,
	output tlb_pkg::paddr_t                  paddr_o,
	output tlb_pkg::rights_t                 rights_o,
	output logic                             miss_o
);
	import tlb_pkg::*;

	tlb_fill_if  fill_bus [TLB_WAYS] ();
	way_result_t way_results [TLB_WAYS];
	// request fields aligned with the way results
	logic        req_valid_q;
	vaddr_t      req_vaddr_q;
	logic        req_xlat_en_q;

	tlb_fill_ctrl u_fill_ctrl (
		.clk_g       (clk_g),
		.rst_i       (rst_i),
		.s_awaddr_i  (s_awaddr_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_bresp_o   (s_bresp_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_araddr_i  (s_araddr_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.fill        (fill_bus)
	);

	// one storage way per index
	for (genvar g = 0; g < TLB_WAYS; g++) begin : g_way
		tlb_way u_way (
			.clk_g          (clk_g),
			.rst_i          (rst_i),
			.fill           (fill_bus[g]),
			.lookup_vaddr_i (vaddr_i),
			.lookup_asid_i  (asid_i),
			.result_o       (way_results[g])
		);
	end

	// stage 1 delay of the request beside the way read
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			req_valid_q <= 1'b0;
		end else begin
			req_valid_q <= lookup_valid_i;
		end
	end

	always_ff @(posedge clk_g) begin
		req_vaddr_q   <= vaddr_i;
		req_xlat_en_q <= xlat_en_i;
	end

	tlb_hit_select u_hit_select (
		.clk_g          (clk_g),
		.rst_i          (rst_i),
		.results_i      (way_results),
		.req_valid_i    (req_valid_q),
		.req_vaddr_i    (req_vaddr_q),
		.req_xlat_en_i  (req_xlat_en_q),
		.result_valid_o (result_valid_o),
		.paddr_o        (paddr_o),
		.rights_o       (rights_o),
		.miss_o         (miss_o)
	);

endmodule

// File: src/tlb_way.sv
`timescale 1ns/1ns

module tlb_way (
	input  logic                clk_g,
	input  logic                rst_i,
	tlb_fill_if.way             fill,
	input  tlb_pkg::vaddr_t     lookup_vaddr_i,
	input  tlb_pkg::asid_t      lookup_asid_i,
	output tlb_pkg::way_result_t result_o
);
	import tlb_pkg::*;

	// entry payload, no reset
	tlb_entry_t          mem [TLB_SETS];
	// valid bits kept apart so reset and flush clear them in one step
	logic [TLB_SETS-1:0] valid_q;
	logic [SET_BITS-1:0] rd_set;
	tlb_entry_t          rd_entry;
	vpn_t                lookup_vpn;
	logic                rd_hit;

	// ====================
	// fill side
	// ====================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (fill.flush) begin
			valid_q <= '0;
		end else if (fill.wr_en) begin
			valid_q[fill.wr_set] <= fill.wr_entry.valid;
		end
	end

	always_ff @(posedge clk_g) begin
		if (fill.wr_en) begin
			mem[fill.wr_set] <= fill.wr_entry;
		end
	end

	// ====================
	// lookup side
	// ====================
	assign lookup_vpn = lookup_vaddr_i[31:PAGE_BITS];
	// set index from the low vpn bits, vaddr[15:12]
	assign rd_set = lookup_vpn[SET_BITS-1:0];

	always_comb begin
		rd_entry       = mem[rd_set];
		// stored valid bit is overridden by the flushable copy
		rd_entry.valid = valid_q[rd_set];
	end

	// hit needs valid, full vpn match, and asid match unless global
	assign rd_hit = rd_entry.valid
		&& (rd_entry.vpn == lookup_vpn)
		&& (rd_entry.glob || (rd_entry.asid == lookup_asid_i));

	// registered every cycle, one lookup per clock
	always_ff @(posedge clk_g) begin
		result_o.hit   <= rd_hit;
		result_o.entry <= rd_entry;
	end

	// the controller never writes and flushes in one cycle
	a_no_wr_flush: assert property (@(posedge clk_g) disable iff (rst_i)
		!(fill.wr_en && fill.flush));

endmodule

// File: testbench/tlb_model.svh
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

// ====================
// reference copy of the buffer
// ====================
tlb_entry_t          model_mem [TLB_WAYS][TLB_SETS];
logic [WAY_BITS-1:0] model_victim;
// staged register contents
vpn_t                model_vpn;
ppn_t                model_ppn;
asid_t               model_asid;
rights_t             model_rights;
logic                model_valid;
logic                model_glob;

function automatic void model_clear();
	for (int w = 0; w < TLB_WAYS; w++)
		for (int s = 0; s < TLB_SETS; s++)
			model_mem[w][s] = '0;
	model_victim = '0;
endfunction

// writable offsets answer OKAY
function automatic logic model_write_ok(input logic [7:0] addr);
	return addr == 8'h00 || addr == 8'h04 || addr == 8'h08 || addr == 8'h0C || addr == 8'h10;
endfunction

function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
	int way;
	case (addr)
		8'h00: model_vpn = data[19:0];
		8'h04: model_ppn = data[19:0];
		8'h08: begin
			model_valid  = data[0];
			model_glob   = data[1];
			model_rights = data[4:2];
			model_asid   = data[15:8];
		end
		8'h0C: begin
			// bit 31 picks the round-robin victim
			way = data[31] ? int'(model_victim) : int'(data[1:0]);
			model_mem[way][model_vpn[3:0]] = {model_valid, model_glob, model_asid,
				model_vpn, model_ppn, model_rights};
			if (data[31])
				model_victim = model_victim + 1'b1;
		end
		8'h10: begin
			for (int w = 0; w < TLB_WAYS; w++)
				for (int s = 0; s < TLB_SETS; s++)
					model_mem[w][s].valid = 1'b0;
		end
		default: ;
	endcase
endfunction

function automatic void model_read(input logic [7:0] addr, output logic [31:0] data,
	output logic ok);
	data = '0;
	ok   = 1'b1;
	case (addr)
		8'h00: data[19:0] = model_vpn;
		8'h04: data[19:0] = model_ppn;
		8'h08: data = {16'h0, model_asid, 3'b000, model_rights, model_glob, model_valid};
		8'h0C, 8'h10: ;
		8'h14: data[1:0] = model_victim;
		default: ok = 1'b0;
	endcase
endfunction

// translation rule, disabled translation passes the address through
function automatic void model_translate(input vaddr_t va, input asid_t asid, input logic xlat,
	output paddr_t pa, output rights_t r, output logic miss);
	tlb_entry_t e;
	pa   = '0;
	r    = '0;
	miss = 1'b1;
	if (!xlat) begin
		pa   = va;
		r    = 3'b111;
		miss = 1'b0;
	end else begin
		for (int w = 0; w < TLB_WAYS; w++) begin
			e = model_mem[w][va[15:12]];
			if (e.valid && e.vpn == va[31:12] && (e.glob || e.asid == asid)) begin
				pa   = {e.ppn, va[11:0]};
				r    = e.rights;
				miss = 1'b0;
			end
		end
	end
endfunction

`endif

// File: testbench/tb_tlb.sv
`timescale 1ns/1ns

module tb_tlb;
	import tlb_pkg::*;
	import axil_pkg::*;

	localparam int SEED        = 96;
	localparam int N_RAND_FILL = 20;
	localparam int N_RAND_LOOK = 40;
	localparam int N_RR        = 5;
	// bus transactions and lookups bound the run length
	localparam int MAX_TXN     = N_RAND_FILL * 4 + 8 + N_RR * 5 + 40;
	localparam int WORST_HS    = 12;
	localparam int MAX_LOOK    = 400;
	localparam int LIMIT       = MAX_TXN * WORST_HS + MAX_LOOK * 4 + 500;

	logic clk_g, rst_i;
	logic [7:0] s_awaddr_i, s_araddr_i;
	logic [31:0] s_wdata_i, s_rdata_o;
	logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
	logic s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
	logic [1:0] s_bresp_o, s_rresp_o;
	logic lookup_valid_i, xlat_en_i, result_valid_o, miss_o;
	vaddr_t vaddr_i;
	asid_t asid_i;
	paddr_t paddr_o;
	rights_t rights_o;

	int cycles = 0;
	int value_errs = 0;
	int proto_errs = 0;

	typedef struct {
		int      due;
		paddr_t  paddr;
		rights_t rights;
		logic    miss;
	} expect_t;
	expect_t pending [$];
	vaddr_t flushed [$];

	`include "tlb_model.svh"

	tlb_top uut (.*);

	initial begin
		clk_g = 1'b0;
		forever #50 clk_g = ~clk_g;
	end

	always @(posedge clk_g) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	// ====================
	// compare tasks
	// ====================
	task automatic check_paddr(input paddr_t got, input paddr_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("ERROR paddr_o got %h expected %h", got, exp);
		end
	endtask

	task automatic check_rights(input rights_t got, input rights_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("ERROR rights_o got %h expected %h", got, exp);
		end
	endtask

	task automatic check_miss(input logic got, input logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("ERROR miss_o got %h expected %h", got, exp);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("ERROR s_rdata_o got %h expected %h", got, exp);
		end
	endtask

	// results are due exactly two edges after the sampling edge
	always @(negedge clk_g) begin
		expect_t e;
		if (!rst_i) begin
			if (pending.size() > 0 && pending[0].due == cycles) begin
				e = pending.pop_front();
				if (!result_valid_o) begin
					proto_errs++;
					$display("result_valid_o stayed low when a lookup result was due");
				end
				check_paddr(paddr_o, e.paddr);
				check_rights(rights_o, e.rights);
				check_miss(miss_o, e.miss);
			end else if (result_valid_o) begin
				proto_errs++;
				$display("result_valid_o rose with no lookup outstanding");
			end
		end
	end

	// ====================
	// bus and lookup drivers
	// ====================
	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		@(posedge clk_g);
		s_awaddr_i  <= addr;
		s_wdata_i   <= data;
		s_awvalid_i <= 1'b1;
		s_wvalid_i  <= 1'b1;
		do @(negedge clk_g); while (!s_awready_o);
		// address and data are taken in the same cycle
		if (!s_wready_o) begin
			proto_errs++;
			$display("write data was not accepted together with the write address");
		end
		@(posedge clk_g);
		s_awvalid_i <= 1'b0;
		s_wvalid_i  <= 1'b0;
		@(negedge clk_g);
		if (!s_bvalid_o) begin
			proto_errs++;
			$display("write response did not follow the accepted write");
		end
		resp = s_bresp_o;
		repeat ($urandom_range(0, 3)) @(posedge clk_g);
		@(posedge clk_g);
		s_bready_i <= 1'b1;
		@(posedge clk_g);
		s_bready_i <= 1'b0;
		check_resp("s_bresp_o", resp, model_write_ok(addr) ? RESP_OKAY : RESP_SLVERR);
		model_write(addr, data);
	endtask

	task automatic axi_read(input logic [7:0] addr);
		logic [31:0] exp_data;
		logic exp_ok;
		@(posedge clk_g);
		s_araddr_i  <= addr;
		s_arvalid_i <= 1'b1;
		do @(negedge clk_g); while (!s_arready_o);
		@(posedge clk_g);
		s_arvalid_i <= 1'b0;
		@(negedge clk_g);
		if (!s_rvalid_o) begin
			proto_errs++;
			$display("read data did not follow the accepted address");
		end
		model_read(addr, exp_data, exp_ok);
		check_resp("s_rresp_o", s_rresp_o, exp_ok ? RESP_OKAY : RESP_SLVERR);
		if (exp_ok)
			check_rdata(s_rdata_o, exp_data);
		repeat ($urandom_range(0, 3)) @(posedge clk_g);
		@(posedge clk_g);
		s_rready_i <= 1'b1;
		@(posedge clk_g);
		s_rready_i <= 1'b0;
	endtask

	// picks a vpn in the set that no other valid way already holds
	function automatic vpn_t unique_vpn(input logic [3:0] set, input int skip_way);
		vpn_t v;
		logic clash;
		do begin
			v = {16'($urandom), set};
			clash = 1'b0;
			for (int w = 0; w < TLB_WAYS; w++)
				if (w != skip_way && model_mem[w][set].valid && model_mem[w][set].vpn == v)
					clash = 1'b1;
		end while (clash);
		return v;
	endfunction

	task automatic commit_entry(input vpn_t vpn, input asid_t asid, input logic glob,
		input logic valid, input logic rr, input logic [1:0] way);
		axi_write(REG_VPN, {12'($urandom), vpn});
		axi_write(REG_PPN, $urandom);
		axi_write(REG_ATTR, {16'($urandom), asid, 3'($urandom), 3'($urandom), glob, valid});
		axi_write(REG_COMMIT, rr ? {1'b1, 31'($urandom)} : {1'b0, 29'($urandom), way});
	endtask

	task automatic issue_lookup(input vaddr_t va, input asid_t asid, input logic xlat);
		expect_t e;
		@(posedge clk_g);
		lookup_valid_i <= 1'b1;
		vaddr_i        <= va;
		asid_i         <= asid;
		xlat_en_i      <= xlat;
		model_translate(va, asid, xlat, e.paddr, e.rights, e.miss);
		// cycles still holds its value from before this edge
		e.due = cycles + 3;
		pending.push_back(e);
	endtask

	task automatic end_lookups();
		@(posedge clk_g);
		lookup_valid_i <= 1'b0;
		while (pending.size() > 0)
			@(posedge clk_g);
	endtask

	task automatic lookup_stored(input logic xlat);
		for (int w = 0; w < TLB_WAYS; w++)
			for (int s = 0; s < TLB_SETS; s++)
				if (model_mem[w][s].valid)
					issue_lookup({model_mem[w][s].vpn, 12'($urandom)}, model_mem[w][s].asid, xlat);
	endtask

	task automatic lookup_random(input int n, input logic xlat);
		for (int i = 0; i < n; i++)
			issue_lookup($urandom, $urandom, xlat);
	endtask

	// ====================
	// test sequence
	// ====================
	initial begin
		logic [3:0] set;
		logic [1:0] way;
		vpn_t v1, v2;
		vpn_t rr_vpn [N_RR];
		asid_t a;
		void'($urandom(SEED));
		rst_i = 1'b1;
		{s_awaddr_i, s_wdata_i, s_awvalid_i, s_wvalid_i, s_bready_i} = '0;
		{s_araddr_i, s_arvalid_i, s_rready_i} = '0;
		{lookup_valid_i, vaddr_i, asid_i, xlat_en_i} = '0;
		model_clear();
		repeat (2) @(posedge clk_g);
		rst_i <= 1'b0;

		// random fills to explicit ways, some left invalid
		for (int i = 0; i < N_RAND_FILL; i++) begin
			way = 2'($urandom);
			set = 4'($urandom);
			commit_entry(unique_vpn(set, way), $urandom, $urandom_range(0, 3) == 0,
				$urandom_range(0, 7) != 0, 1'b0, way);
		end
		lookup_stored(1'b1);
		lookup_random(N_RAND_LOOK, 1'b1);
		end_lookups();

		// asid match against a private and a global entry
		a  = $urandom;
		v1 = unique_vpn(4'($urandom), 0);
		commit_entry(v1, a, 1'b0, 1'b1, 1'b0, 2'd0);
		v2 = unique_vpn(4'($urandom), 1);
		commit_entry(v2, a, 1'b1, 1'b1, 1'b0, 2'd1);
		issue_lookup({v1, 12'($urandom)}, a, 1'b1);
		issue_lookup({v1, 12'($urandom)}, a + 8'd1, 1'b1);
		for (int i = 0; i < 3; i++)
			issue_lookup({v2, 12'($urandom)}, $urandom, 1'b1);
		end_lookups();

		// round-robin into one set, the fifth commit evicts the first
		set = 4'($urandom);
		for (int i = 0; i < N_RR; i++) begin
			axi_read(REG_VICTIM);
			rr_vpn[i] = unique_vpn(set, model_victim);
			commit_entry(rr_vpn[i], 8'h5A, 1'b0, 1'b1, 1'b1, 2'd0);
		end
		axi_read(REG_VICTIM);
		for (int i = 0; i < N_RR; i++)
			issue_lookup({rr_vpn[i], 12'($urandom)}, 8'h5A, 1'b1);
		end_lookups();

		// undefined offsets and staged readback
		axi_write(REG_VICTIM, $urandom);
		axi_write(8'h18, $urandom);
		axi_write(8'h80, $urandom);
		axi_read(8'h18);
		axi_read(8'h02);
		axi_read(8'hFC);
		axi_read(REG_VICTIM);
		axi_write(REG_VPN, $urandom);
		axi_read(REG_VPN);
		axi_write(REG_PPN, $urandom);
		axi_read(REG_PPN);
		axi_write(REG_ATTR, $urandom);
		axi_read(REG_ATTR);
		axi_read(REG_COMMIT);
		axi_read(REG_FLUSH);
		lookup_stored(1'b1);
		end_lookups();

		// pass-through with translation off
		lookup_stored(1'b0);
		lookup_random(20, 1'b0);
		end_lookups();

		// flush, then every earlier mapping must miss
		for (int w = 0; w < TLB_WAYS; w++)
			for (int s = 0; s < TLB_SETS; s++)
				if (model_mem[w][s].valid)
					flushed.push_back({model_mem[w][s].vpn, 12'h0});
		axi_write(REG_FLUSH, $urandom);
		foreach (flushed[i])
			issue_lookup(flushed[i] | vaddr_t'($urandom_range(0, 4095)), $urandom, 1'b1);
		lookup_random(20, 1'b1);
		end_lookups();

		$display("value errors %0d, protocol errors %0d", value_errs, proto_errs);
		if (value_errs + proto_errs == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
